// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module branch_predictor_tb > build.log 2>&1 ||
	{ echo "build failed, see build.log"; exit 1; }
./obj_dir/Vbranch_predictor_tb 2>&1 | tee sim.log
grep -q "ERRORS FOUND" sim.log &&
	{ echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log ||
	{ echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

// File: source/bpred_pkg.sv
package bpred_pkg;

	// rv32i opcodes the predictor cares about
	typedef enum logic [6:0] {
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011
	} opcode_t;

	// link registers per the rv32i hint table
	localparam logic [4:0] LINK_RA = 5'd1;
	localparam logic [4:0] LINK_T0 = 5'd5;

	// way write fields sized for up to 256 sets
	// each way keeps only the low bits it needs
	localparam int WR_SET_W = 8;
	localparam int WR_TAG_W = 30;

	// one fetch slot, counts when valid at a rising edge
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_req_t;

	// branch or jump outcome from execute
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] target;
		logic        taken;
	} resolve_t;

	// return prediction from the stack
	typedef struct packed {
		logic        pop_valid;
		logic [31:0] target;
	} ras_rsp_t;

	// lookup answer of a single way
	typedef struct packed {
		logic        hit;
		logic [31:0] target;
		logic [1:0]  counter;
	} way_rsp_t;

	// training command for a single way
	typedef struct packed {
		logic                en;
		logic                alloc;
		logic [WR_SET_W-1:0] set;
		logic [WR_TAG_W-1:0] tag;
		logic [31:0]         target;
		logic                taken;
	} way_wr_t;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		BTB  = 2'd1,
		RAS  = 2'd2
	} pred_src_t;

	typedef struct packed {
		logic        valid;
		logic        taken;
		logic [31:0] target;
		pred_src_t   source;
	} prediction_t;

endpackage

// File: source/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
	import bpred_pkg::*;
#(
	parameter int BTB_SETS  = 16,
	parameter int BTB_WAYS  = 4,
	parameter int RAS_DEPTH = 4
) (
	input  logic        CLK,
	input  logic        nRST,
	input  fetch_req_t  fetch,
	input  resolve_t    resolve,
	output prediction_t pred
);
	localparam int SET_W = $clog2(BTB_SETS);
	localparam int TAG_W = 30 - SET_W;

	// shared lookup index for all ways
	logic [SET_W-1:0]    lookup_set;
	logic [TAG_W-1:0]    lookup_tag;
	// per way training and answers
	logic [BTB_WAYS-1:0] upd_hit;
	way_wr_t             way_wr [BTB_WAYS];
	way_rsp_t            way_rsp [BTB_WAYS];
	ras_rsp_t            ras_rsp;

	btb_index #(.BTB_SETS(BTB_SETS), .BTB_WAYS(BTB_WAYS)) u_index (
		.CLK        (CLK),
		.nRST       (nRST),
		.fetch_pc   (fetch.pc),
		.resolve    (resolve),
		.lookup_set (lookup_set),
		.lookup_tag (lookup_tag),
		.upd_hit    (upd_hit),
		.way_wr     (way_wr)
	);

	for (genvar w = 0; w < BTB_WAYS; w++) begin : g_way
		btb_way #(.BTB_SETS(BTB_SETS)) u_way (
			.CLK        (CLK),
			.nRST       (nRST),
			.lookup_set (lookup_set),
			.lookup_tag (lookup_tag),
			.wr         (way_wr[w]),
			.upd_hit    (upd_hit[w]),
			.rsp        (way_rsp[w])
		);
	end

	return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
		.CLK   (CLK),
		.nRST  (nRST),
		.fetch (fetch),
		.ras   (ras_rsp)
	);

	way_select #(.BTB_WAYS(BTB_WAYS)) u_select (
		.CLK         (CLK),
		.nRST        (nRST),
		.fetch_valid (fetch.valid),
		.ways        (way_rsp),
		.ras         (ras_rsp),
		.pred        (pred)
	);

endmodule

// File: source/btb_index.sv
`timescale 1ns/1ps

module btb_index
	import bpred_pkg::*;
#(
	parameter int BTB_SETS = 16,
	parameter int BTB_WAYS = 4
) (
	input  logic                          CLK,
	input  logic                          nRST,
	input  logic [31:0]                   fetch_pc,
	input  resolve_t                      resolve,
	output logic [$clog2(BTB_SETS)-1:0]   lookup_set,
	output logic [29-$clog2(BTB_SETS):0]  lookup_tag,
	input  logic [BTB_WAYS-1:0]           upd_hit,
	output way_wr_t                       way_wr [BTB_WAYS]
);
	localparam int SET_W = $clog2(BTB_SETS);
	localparam int TAG_W = 30 - SET_W;
	localparam int VIC_W = $clog2(BTB_WAYS);

	logic [SET_W-1:0]    res_set;
	logic [TAG_W-1:0]    res_tag;
	logic                alloc;
	logic [BTB_WAYS-1:0] wr_en;
	// round-robin victim per set
	logic [VIC_W-1:0]    victim [BTB_SETS];

	// word aligned, set from low bits, tag above
	assign lookup_set = fetch_pc[2 +: SET_W];
	assign lookup_tag = fetch_pc[31 -: TAG_W];
	assign res_set    = resolve.pc[2 +: SET_W];
	assign res_tag    = resolve.pc[31 -: TAG_W];

	// only a taken miss allocates
	assign alloc = resolve.valid && resolve.taken && !(|upd_hit);

	always_comb begin
		for (int i = 0; i < BTB_WAYS; i++) begin
			wr_en[i] = (resolve.valid && upd_hit[i]) ||
				(alloc && victim[res_set] == VIC_W'(i));
			way_wr[i].en     = wr_en[i];
			way_wr[i].alloc  = alloc;
			way_wr[i].set    = WR_SET_W'(res_set);
			way_wr[i].tag    = WR_TAG_W'(res_tag);
			way_wr[i].target = resolve.target;
			way_wr[i].taken  = resolve.taken;
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < BTB_SETS; s++) begin
				victim[s] <= '0;
			end
		end else if (alloc) begin
			if (victim[res_set] == VIC_W'(BTB_WAYS - 1)) begin
				victim[res_set] <= '0;
			end else begin
				victim[res_set] <= victim[res_set] + 1'b1;
			end
		end
	end

	// a resolve trains at most one way
	assert property (@(posedge CLK) disable iff (!nRST) $onehot0(wr_en));

endmodule

// File: source/btb_way.sv
`timescale 1ns/1ps

module btb_way
	import bpred_pkg::*;
#(
	parameter int BTB_SETS = 16
) (
	input  logic                          CLK,
	input  logic                          nRST,
	input  logic [$clog2(BTB_SETS)-1:0]   lookup_set,
	input  logic [29-$clog2(BTB_SETS):0]  lookup_tag,
	input  way_wr_t                       wr,
	output logic                          upd_hit,
	output way_rsp_t                      rsp
);
	localparam int SET_W = $clog2(BTB_SETS);
	localparam int TAG_W = 30 - SET_W;

	// per set entry state
	logic [BTB_SETS-1:0] valid;
	logic [TAG_W-1:0]    tags [BTB_SETS];
	logic [31:0]         targets [BTB_SETS];
	logic [1:0]          ctr [BTB_SETS];

	logic [SET_W-1:0] wr_set;
	logic [TAG_W-1:0] wr_tag;

	assign wr_set = wr.set[SET_W-1:0];
	assign wr_tag = wr.tag[TAG_W-1:0];

	// fetch side compare
	assign rsp.hit     = valid[lookup_set] && (tags[lookup_set] == lookup_tag);
	assign rsp.target  = targets[lookup_set];
	assign rsp.counter = ctr[lookup_set];

	// resolve side compare, independent of wr.en
	assign upd_hit = valid[wr_set] && (tags[wr_set] == wr_tag);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			for (int s = 0; s < BTB_SETS; s++) begin
				ctr[s] <= 2'd0;
			end
		end else if (wr.en) begin
			if (wr.alloc) begin
				// new entries start weakly taken
				valid[wr_set] <= 1'b1;
				ctr[wr_set]   <= 2'd2;
			end else if (wr.taken) begin
				if (ctr[wr_set] != 2'd3) begin
					ctr[wr_set] <= ctr[wr_set] + 2'd1;
				end
			end else if (ctr[wr_set] != 2'd0) begin
				ctr[wr_set] <= ctr[wr_set] - 2'd1;
			end
		end
	end

	// taken writes refresh the target
	always_ff @(posedge CLK) begin
		if (wr.en && (wr.alloc || wr.taken)) begin
			tags[wr_set]    <= wr_tag;
			targets[wr_set] <= wr.target;
		end
	end

endmodule

// File: source/return_stack.sv
`timescale 1ns/1ps

module return_stack
	import bpred_pkg::*;
#(
	parameter int RAS_DEPTH = 4
) (
	input  logic       CLK,
	input  logic       nRST,
	input  fetch_req_t fetch,
	output ras_rsp_t   ras
);
	localparam int PTR_W = $clog2(RAS_DEPTH);
	localparam int CNT_W = $clog2(RAS_DEPTH + 1);

	// decoded fields of the fetched word
	logic [6:0]  opcode;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic        rd_link;
	logic        rs1_link;
	logic        is_jal;
	logic        is_jalr;
	logic [31:0] link_addr;

	// stack operations for this request
	logic do_push;
	logic do_pop;
	logic do_swap;
	logic push_any;

	// circular storage, ptr is the next free slot
	logic [31:0]      stack [RAS_DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] top;
	logic [PTR_W-1:0] ptr_inc;
	logic [CNT_W-1:0] count;
	logic             empty;

	assign opcode    = fetch.instr[6:0];
	assign rd        = fetch.instr[11:7];
	assign rs1       = fetch.instr[19:15];
	assign rd_link   = (rd == LINK_RA) || (rd == LINK_T0);
	assign rs1_link  = (rs1 == LINK_RA) || (rs1 == LINK_T0);
	assign is_jal    = fetch.valid && (opcode == JAL);
	assign is_jalr   = fetch.valid && (opcode == JALR);
	assign link_addr = fetch.pc + 32'd4;

	// hint table: rd link only or equal links push
	// rs1 link only pops, two different links swap
	assign do_push = (is_jal && rd_link) ||
		(is_jalr && rd_link && (!rs1_link || rd == rs1));
	assign do_pop  = is_jalr && !rd_link && rs1_link;
	assign do_swap = is_jalr && rd_link && rs1_link && (rd != rs1);

	assign empty   = (count == '0);
	// swap on an empty stack has nothing to pop, so it just pushes
	assign push_any = do_push || (do_swap && empty);

	// wrap both ways around the ring
	assign top     = (ptr == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr - 1'b1;
	assign ptr_inc = (ptr == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr + 1'b1;

	// top before the request edge
	assign ras.pop_valid = (do_pop || do_swap) && !empty;
	assign ras.target    = ras.pop_valid ? stack[top] : '0;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ptr   <= '0;
			count <= '0;
		end else if (push_any) begin
			ptr <= ptr_inc;
			// full stack drops the oldest entry
			if (count != CNT_W'(RAS_DEPTH)) begin
				count <= count + 1'b1;
			end
		end else if (do_pop && !empty) begin
			ptr   <= top;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push_any) begin
			stack[ptr] <= link_addr;
		end else if (do_swap) begin
			// pop then push lands on the same slot
			stack[top] <= link_addr;
		end
	end

	// saturating count must stay within the ring
	assert property (@(posedge CLK) disable iff (!nRST)
		count <= CNT_W'(RAS_DEPTH));

endmodule

// File: source/way_select.sv
`timescale 1ns/1ps

module way_select
	import bpred_pkg::*;
#(
	parameter int BTB_WAYS = 4
) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic        fetch_valid,
	input  way_rsp_t    ways [BTB_WAYS],
	input  ras_rsp_t    ras,
	output prediction_t pred
);
	logic [BTB_WAYS-1:0] hit_vec;
	way_rsp_t            merged;
	prediction_t         pred_next;

	// at most one way hits, so OR of masked answers
	always_comb begin
		merged = '0;
		for (int i = 0; i < BTB_WAYS; i++) begin
			hit_vec[i] = ways[i].hit;
			if (ways[i].hit) begin
				merged.hit     = 1'b1;
				merged.target  = merged.target | ways[i].target;
				merged.counter = merged.counter | ways[i].counter;
			end
		end
	end

	// stack beats buffer, buffer beats fall-through
	always_comb begin
		pred_next = '0;
		if (fetch_valid) begin
			pred_next.valid = 1'b1;
			if (ras.pop_valid) begin
				pred_next.taken  = 1'b1;
				pred_next.target = ras.target;
				pred_next.source = RAS;
			end else if (merged.hit) begin
				// counter msb set means 2 or 3
				pred_next.taken  = merged.counter[1];
				pred_next.target = merged.target;
				pred_next.source = BTB;
			end
		end
	end

	// single output register of the unit
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			pred <= '0;
		end else begin
			pred <= pred_next;
		end
	end

	// allocation only on a miss keeps tags unique across ways
	assert property (@(posedge CLK) disable iff (!nRST)
		fetch_valid |-> $onehot0(hit_vec));

endmodule

// File: tests/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb
	import bpred_pkg::*;
();
	// must match the DUT defaults
	localparam int BTB_WAYS  = 4;
	localparam int RAS_DEPTH = 4;
	localparam int NUM_TESTS = 6;

	logic        CLK;
	logic        nRST;
	fetch_req_t  fetch;
	resolve_t    resolve;
	prediction_t pred;

	// stimulus table, one row per cycle
	fetch_req_t  fetch_tab [$];
	resolve_t    res_tab [$];
	prediction_t exp_tab [$];
	int          test_tab [$];

	string test_names [NUM_TESTS] = '{"cold miss", "training", "replacement",
		"nested calls", "coroutine swap", "overflow"};

	int          errors = 0;
	int          test_errs = 0;
	int          tests_passed = 0;
	int          cycles = 0;
	int          limit = 1000;
	logic [31:0] lcg_state = 32'd57;

	branch_predictor DUT (
		.CLK     (CLK),
		.nRST    (nRST),
		.fetch   (fetch),
		.resolve (resolve),
		.pred    (pred)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// run limit from the table length
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: table not finished after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// rv32i encodings, only opcode rd rs1 matter here
	function automatic logic [31:0] enc_jal(input logic [4:0] rd);
		return {20'h0, rd, JAL};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'h0, rs1, 3'b000, rd, JALR};
	endfunction

	function automatic fetch_req_t fetch_of(input logic [31:0] pc, input logic [31:0] instr);
		return '{valid: 1'b1, pc: pc, instr: instr};
	endfunction

	function automatic resolve_t resolve_of(input logic [31:0] pc, input logic [31:0] target,
		input logic taken);
		return '{valid: 1'b1, pc: pc, target: target, taken: taken};
	endfunction

	// expected answer for a valid fetch
	function automatic prediction_t pred_of(input logic taken, input logic [31:0] target,
		input pred_src_t source);
		return '{valid: 1'b1, taken: taken, target: target, source: source};
	endfunction

	task automatic add_row(input int test, input fetch_req_t f, input resolve_t r,
		input prediction_t p);
		test_tab.push_back(test);
		fetch_tab.push_back(f);
		res_tab.push_back(r);
		exp_tab.push_back(p);
	endtask

	task automatic check_pred(input prediction_t got, input prediction_t exp, input int row);
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("[FAIL] row %0d pred: got valid=%h taken=%h target=%h source=%h",
				row, got.valid, got.taken, got.target, got.source);
			$display("[FAIL] row %0d pred: exp valid=%h taken=%h target=%h source=%h",
				row, exp.valid, exp.taken, exp.target, exp.source);
		end
	endtask

	task automatic report_test(input int test);
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %0d %s: pass", test, test_names[test]);
		end else begin
			$display("test %0d %s: %0d mismatches", test, test_names[test], test_errs);
		end
		test_errs = 0;
	endtask

	task automatic build_table();
		logic [31:0] pc;
		logic [31:0] r;
		logic [31:0] branch;
		branch = {25'h0, BRANCH};
		// cold miss, then an idle cycle
		add_row(0, fetch_of(32'h1000, branch), '0, pred_of(1'b0, 32'h0, NONE));
		add_row(0, '0, '0, '0);
		// random pcs in sets 8 to 15, never trained
		for (int i = 0; i < 3; i++) begin
			r  = lcg_next();
			pc = {r[31:6], 1'b1, r[4:2], 2'b00};
			add_row(0, fetch_of(pc, branch), '0, pred_of(1'b0, 32'h0, NONE));
		end
		// training in set 1, counter 2 then 1 then 0
		add_row(1, '0, resolve_of(32'h2004, 32'h3000, 1'b1), '0);
		add_row(1, fetch_of(32'h2004, branch), '0, pred_of(1'b1, 32'h3000, BTB));
		add_row(1, '0, resolve_of(32'h2004, 32'h0, 1'b0), '0);
		add_row(1, fetch_of(32'h2004, branch), '0, pred_of(1'b0, 32'h3000, BTB));
		add_row(1, '0, resolve_of(32'h2004, 32'h0, 1'b0), '0);
		add_row(1, fetch_of(32'h2004, branch), '0, pred_of(1'b0, 32'h3000, BTB));
		// ways+1 tags into set 3, round robin evicts the first
		for (int i = 0; i <= BTB_WAYS; i++) begin
			add_row(2, '0, resolve_of(32'h40 * 32'(i + 1) + 32'hC,
				32'h8000 + 32'h10 * 32'(i), 1'b1), '0);
		end
		add_row(2, fetch_of(32'h4C, branch), '0, pred_of(1'b0, 32'h0, NONE));
		for (int i = 1; i <= BTB_WAYS; i++) begin
			add_row(2, fetch_of(32'h40 * 32'(i + 1) + 32'hC, branch), '0,
				pred_of(1'b1, 32'h8000 + 32'h10 * 32'(i), BTB));
		end
		// three calls, returns come back in reverse
		for (int i = 0; i < 3; i++) begin
			add_row(3, fetch_of(32'h4000 + 32'h100 * 32'(i), enc_jal(LINK_RA)), '0,
				pred_of(1'b0, 32'h0, NONE));
		end
		for (int j = 0; j < 3; j++) begin
			add_row(3, fetch_of(32'h5000 + 32'h40 * 32'(j), enc_jalr(5'd0, LINK_RA)), '0,
				pred_of(1'b1, 32'h4000 + 32'h100 * 32'(2 - j) + 32'd4, RAS));
		end
		add_row(3, fetch_of(32'h50C0, enc_jalr(5'd0, LINK_RA)), '0, pred_of(1'b0, 32'h0, NONE));
		// swap pops old top, leaves its own link
		add_row(4, fetch_of(32'h6000, enc_jal(LINK_RA)), '0, pred_of(1'b0, 32'h0, NONE));
		add_row(4, fetch_of(32'h6100, enc_jalr(LINK_RA, LINK_T0)), '0,
			pred_of(1'b1, 32'h6004, RAS));
		add_row(4, fetch_of(32'h6200, enc_jalr(5'd0, LINK_RA)), '0, pred_of(1'b1, 32'h6104, RAS));
		add_row(4, fetch_of(32'h6240, enc_jalr(5'd0, LINK_RA)), '0, pred_of(1'b0, 32'h0, NONE));
		// depth+1 pushes, oldest link lost
		for (int i = 0; i <= RAS_DEPTH; i++) begin
			add_row(5, fetch_of(32'h7000 + 32'h40 * 32'(i), enc_jal(LINK_RA)), '0,
				pred_of(1'b0, 32'h0, NONE));
		end
		for (int j = 0; j < RAS_DEPTH; j++) begin
			add_row(5, fetch_of(32'h7800 + 32'h40 * 32'(j), enc_jalr(5'd0, LINK_RA)), '0,
				pred_of(1'b1, 32'h7000 + 32'h40 * 32'(RAS_DEPTH - j) + 32'd4, RAS));
		end
		add_row(5, fetch_of(32'h7900, enc_jalr(5'd0, LINK_RA)), '0, pred_of(1'b0, 32'h0, NONE));
	endtask

	initial begin
		fetch   = '0;
		resolve = '0;
		nRST    = 1'b0;
		build_table();
		limit = fetch_tab.size() * 2 + 20;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		// drive on falling edge, registered answer one edge later
		for (int i = 0; i < fetch_tab.size(); i++) begin
			fetch   = fetch_tab[i];
			resolve = res_tab[i];
			@(posedge CLK);
			@(negedge CLK);
			check_pred(pred, exp_tab[i], i);
			if (i == fetch_tab.size() - 1 || test_tab[i + 1] != test_tab[i]) begin
				report_test(test_tab[i]);
			end
		end
		fetch   = '0;
		resolve = '0;
		$display("tests: %0d run, %0d passed, %0d errors", NUM_TESTS, tests_passed, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: vlog.f
source/bpred_pkg.sv
source/return_stack.sv
source/btb_index.sv
source/btb_way.sv
source/way_select.sv
source/branch_predictor.sv
tests/branch_predictor_tb.sv
